/* Bender.yml */
package:
  name: capture_buf

sources:
  - src/buf_cfg_pkg.sv
  - src/axil_pkg.sv
  - src/ram_bank.sv
  - src/asym_ram.sv
  - src/sample_writer.sv
  - src/frame_reader.sv
  - src/capture_top.sv
  - target: dv
    files:
      - dv/capture_checker.sv
      - dv/capture_tb.sv

/* dv/capture_checker.sv */
`default_nettype none
`timescale 1ns/100ps

// handshake rules of both AXI4-Lite ports and the buffer write strobe
module capture_checker
   import axil_pkg::*;
(
   input wire logic                   r_clk,
   input wire logic                   arst_n,
   input wire logic                   wr_awvalid,
   input wire logic                   wr_awready,
   input wire logic [axil_addr_w-1:0] wr_awaddr,
   input wire logic                   wr_bvalid,
   input wire logic                   wr_bready,
   input wire logic [1:0]             wr_bresp,
   input wire logic                   rd_arvalid,
   input wire logic                   rd_arready,
   input wire logic                   rd_rvalid,
   input wire logic                   rd_rready,
   input wire logic [axil_data_w-1:0] rd_rdata,
   input wire logic [1:0]             rd_rresp,
   input wire logic                   buf_wr_en
);

   logic rd_busy;

   // read outstanding from AR handshake up to R handshake
   always_ff @(posedge r_clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_busy <= 1'b0;
      end else if (rd_arvalid && rd_arready) begin
         rd_busy <= 1'b1;
      end else if (rd_rvalid && rd_rready) begin
         rd_busy <= 1'b0;
      end
   end

   // address and responses hold under back-pressure
   a_aw_hold: assert property (@(posedge r_clk) disable iff (!arst_n)
      wr_awvalid && !wr_awready |=> wr_awvalid && $stable(wr_awaddr))
      else $error("awvalid or awaddr changed before the AW handshake");

   a_b_hold: assert property (@(posedge r_clk) disable iff (!arst_n)
      wr_bvalid && !wr_bready |=> wr_bvalid && $stable(wr_bresp))
      else $error("B response changed while bready was low");

   a_r_hold: assert property (@(posedge r_clk) disable iff (!arst_n)
      rd_rvalid && !rd_rready |=> rd_rvalid && $stable(rd_rdata) && $stable(rd_rresp))
      else $error("R response changed while rready was low");

   // memory read takes one cycle, data register one more
   a_r_latency: assert property (@(posedge r_clk) disable iff (!arst_n)
      rd_arvalid && rd_arready |=> !rd_rvalid ##1 rd_rvalid)
      else $error("rvalid did not follow AR acceptance by two edges");

   a_one_read: assert property (@(posedge r_clk) disable iff (!arst_n)
      rd_busy |-> !rd_arready)
      else $error("AR accepted while a read response is pending");

   a_wr_pulse: assert property (@(posedge r_clk) disable iff (!arst_n)
      buf_wr_en |=> !buf_wr_en)
      else $error("buffer write strobe lasted more than one cycle");

endmodule

bind capture_top capture_checker u_chk (
   .r_clk      (r_clk),
   .arst_n     (arst_n),
   .wr_awvalid (wr_awvalid),
   .wr_awready (wr_awready),
   .wr_awaddr  (wr_awaddr),
   .wr_bvalid  (wr_bvalid),
   .wr_bready  (wr_bready),
   .wr_bresp   (wr_bresp),
   .rd_arvalid (rd_arvalid),
   .rd_arready (rd_arready),
   .rd_rvalid  (rd_rvalid),
   .rd_rready  (rd_rready),
   .rd_rdata   (rd_rdata),
   .rd_rresp   (rd_rresp),
   .buf_wr_en  (buf_wr_en)
);

`default_nettype wire

/* dv/capture_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module capture_tb
   import axil_pkg::*;
   import buf_cfg_pkg::*;
();

   // transfers over all tests, 8 cycles each, with a 4x margin
   localparam int xfer_n = 81 + 6 + 1287 + 1 + 8 + 5;
   localparam int timeout_cycles = 4 * xfer_n * 8;

   logic r_clk;
   logic arst_n;
   logic wr_awvalid;
   logic wr_awready;
   logic wr_wvalid;
   logic wr_wready;
   logic wr_bvalid;
   logic wr_bready;
   logic rd_arvalid;
   logic rd_arready;
   logic rd_rvalid;
   logic rd_rready;
   logic [axil_addr_w-1:0] wr_awaddr;
   logic [axil_addr_w-1:0] rd_araddr;
   logic [axil_data_w-1:0] wr_wdata;
   logic [axil_data_w-1:0] rd_rdata;
   logic [1:0] wr_bresp;
   logic [1:0] rd_rresp;

   // reference view of the buffer
   logic [w_data_w-1:0] mem_model [2**byte_addr_w];
   int ptr_model;
   logic [chksum_w-1:0] sum_model;
   logic [31:0] lfsr;
   int checks;
   int errors;
   int cycles;

   capture_top uut (.*);

   always #20 r_clk = ~r_clk;

   always @(posedge r_clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         $display("timeout after %0d cycles, a handshake never completed", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // galois lfsr, one step per bit
   function automatic logic [w_data_w-1:0] rand_byte();
      logic [w_data_w-1:0] b;
      for (int i = 0; i < w_data_w; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         b[i] = lfsr[0];
      end
      return b;
   endfunction

   task automatic check_flag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
      end
   endtask

   task automatic check_sum(input string name, input logic [chksum_w-1:0] got,
                            input logic [chksum_w-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %04h exp %04h", $time, name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input rd_word_u got, input rd_word_u exp);
      checks++;
      for (int l = 0; l < lane_n; l++) begin
         if (got.lanes[l] !== exp.lanes[l]) begin
            $display("CHECK FAILED t=%0t %s lane %0d got %02h exp %02h",
                     $time, name, l, got.lanes[l], exp.lanes[l]);
         end
      end
      if (got.raw !== exp.raw) begin
         errors++;
         $display("CHECK FAILED t=%0t %s got %08h exp %08h", $time, name, got.raw, exp.raw);
      end
   endtask

   task automatic axil_write(input logic [axil_addr_w-1:0] addr,
                             input logic [axil_data_w-1:0] data, input int w_delay,
                             input int b_stall, output logic [1:0] resp);
      logic [1:0] first;
      @(negedge r_clk);
      wr_awvalid = 1'b1;
      wr_awaddr  = addr;
      if (w_delay == 0) begin
         wr_wvalid = 1'b1;
         wr_wdata  = data;
      end
      while (!wr_awready) @(negedge r_clk);
      @(negedge r_clk);
      wr_awvalid = 1'b0;
      wr_wvalid  = 1'b0;
      // W trails AW by a few cycles
      if (w_delay > 0) begin
         check_flag("wr_awready after AW", wr_awready, 1'b0);
         repeat (w_delay - 1) @(negedge r_clk);
         wr_wvalid = 1'b1;
         wr_wdata  = data;
         while (!wr_wready) @(negedge r_clk);
         @(negedge r_clk);
         wr_wvalid = 1'b0;
      end
      while (!wr_bvalid) @(negedge r_clk);
      first = wr_bresp;
      repeat (b_stall) begin
         @(negedge r_clk);
         if (!wr_bvalid) begin
            errors++;
            $display("bvalid dropped at %0t while bready was low", $time);
         end
         check_resp("wr_bresp held", wr_bresp, first);
         check_flag("wr_awready stalled", wr_awready, 1'b0);
         check_flag("wr_wready stalled", wr_wready, 1'b0);
      end
      wr_bready = 1'b1;
      resp = wr_bresp;
      @(negedge r_clk);
      wr_bready = 1'b0;
   endtask

   task automatic axil_read(input logic [axil_addr_w-1:0] addr, input int r_stall,
                            output rd_word_u data, output logic [1:0] resp);
      rd_word_u first;
      @(negedge r_clk);
      rd_arvalid = 1'b1;
      rd_araddr  = addr;
      while (!rd_arready) @(negedge r_clk);
      @(negedge r_clk);
      rd_arvalid = 1'b0;
      while (!rd_rvalid) @(negedge r_clk);
      first = rd_rdata;
      repeat (r_stall) begin
         @(negedge r_clk);
         if (!rd_rvalid) begin
            errors++;
            $display("rvalid dropped at %0t while rready was low", $time);
         end
         check_word("rd_rdata held", rd_rdata, first);
         check_flag("rd_arready stalled", rd_arready, 1'b0);
      end
      rd_rready = 1'b1;
      data = rd_rdata;
      resp = rd_rresp;
      @(negedge r_clk);
      rd_rready = 1'b0;
   endtask

   task automatic set_ptr(input int p);
      logic [1:0] resp;
      axil_write(reg_wptr, p, 0, 0, resp);
      check_resp("wr_bresp", resp, resp_okay);
      ptr_model = p;
   endtask

   task automatic push_byte(input logic [w_data_w-1:0] b, input int w_delay, input int b_stall);
      logic [1:0] resp;
      axil_write(reg_push, {24'h0, b}, w_delay, b_stall, resp);
      check_resp("wr_bresp", resp, resp_okay);
      mem_model[ptr_model] = b;
      ptr_model = (ptr_model + 1) % (2**byte_addr_w);
   endtask

   // byte p lives in word p/4, lane p%4
   task automatic read_and_compare(input int word, input int r_stall);
      rd_word_u got;
      rd_word_u exp;
      logic [1:0] resp;
      axil_read(word * 4, r_stall, got, resp);
      check_resp("rd_rresp", resp, resp_okay);
      for (int l = 0; l < lane_n; l++) begin
         exp.lanes[l] = mem_model[word * lane_n + l];
         sum_model = sum_model + exp.lanes[l];
      end
      check_word("rd_rdata", got, exp);
   endtask

   task automatic check_chksum_reg(input int r_stall);
      rd_word_u got;
      logic [1:0] resp;
      axil_read(reg_chksum, r_stall, got, resp);
      check_resp("rd_rresp", resp, resp_okay);
      check_sum("chksum", got.raw[15:0], sum_model);
      check_sum("rd_rdata[31:16]", got.raw[31:16], '0);
   endtask

   // idle state straight out of reset
   task automatic test_reset_state();
      check_flag("wr_awready", wr_awready, 1'b1);
      check_flag("wr_wready", wr_wready, 1'b1);
      check_flag("wr_bvalid", wr_bvalid, 1'b0);
      check_flag("rd_arready", rd_arready, 1'b1);
      check_flag("rd_rvalid", rd_rvalid, 1'b0);
   endtask

   task automatic test_linear();
      set_ptr(0);
      for (int i = 0; i < 64; i++) begin
         push_byte(rand_byte(), i % 3, 0);
      end
      for (int w = 0; w < 16; w++) begin
         read_and_compare(w, 0);
      end
   endtask

   task automatic test_single_lane();
      set_ptr(10'h021);
      push_byte(rand_byte(), 1, 0);
      read_and_compare(8, 0);
      set_ptr(10'h036);
      push_byte(rand_byte(), 0, 0);
      read_and_compare(13, 0);
   endtask

   task automatic test_wrap();
      set_ptr(0);
      for (int i = 0; i < 1030; i++) begin
         push_byte(rand_byte(), i % 2, 0);
      end
      for (int w = 0; w < 256; w++) begin
         read_and_compare(w, 0);
      end
   endtask

   task automatic test_unmapped();
      rd_word_u got;
      logic [1:0] resp;
      // these would move the pointer if decoded as reg_wptr
      axil_write(12'h008, 32'h3ff, 0, 0, resp);
      check_resp("wr_bresp", resp, resp_slverr);
      axil_write(12'h3fc, 32'h155, 2, 0, resp);
      check_resp("wr_bresp", resp, resp_slverr);
      axil_read(12'h404, 0, got, resp);
      check_resp("rd_rresp", resp, resp_slverr);
      check_word("rd_rdata", got, '0);
      axil_read(12'hffc, 0, got, resp);
      check_resp("rd_rresp", resp, resp_slverr);
      check_word("rd_rdata", got, '0);
      // word under the pointer still holds the wrap data
      read_and_compare(ptr_model / lane_n, 0);
      push_byte(rand_byte(), 0, 0);
      read_and_compare((ptr_model - 1) / lane_n, 0);
      check_chksum_reg(0);
   endtask

   task automatic test_backpressure();
      push_byte(rand_byte(), 0, 5);
      push_byte(rand_byte(), 2, 3);
      read_and_compare((ptr_model - 1) / lane_n, 6);
      read_and_compare(100, 4);
      check_chksum_reg(4);
   endtask

   initial begin
      r_clk      = 1'b0;
      arst_n     = 1'b0;
      wr_awvalid = 1'b0;
      wr_awaddr  = '0;
      wr_wvalid  = 1'b0;
      wr_wdata   = '0;
      wr_bready  = 1'b0;
      rd_arvalid = 1'b0;
      rd_araddr  = '0;
      rd_rready  = 1'b0;
      lfsr       = 32'h68da_aaa1;
      ptr_model  = 0;
      sum_model  = '0;
      checks     = 0;
      errors     = 0;
      cycles     = 0;
      repeat (16) @(posedge r_clk);
      @(negedge r_clk);
      arst_n = 1'b1;
      test_reset_state();
      test_linear();
      test_single_lane();
      test_wrap();
      check_chksum_reg(0);
      test_unmapped();
      test_backpressure();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
src/buf_cfg_pkg.sv
src/axil_pkg.sv
src/ram_bank.sv
src/asym_ram.sv
src/sample_writer.sv
src/frame_reader.sv
src/capture_top.sv
dv/capture_checker.sv
dv/capture_tb.sv

/* src/asym_ram.sv */
`default_nettype none
`timescale 1ns/100ps

module asym_ram
   import buf_cfg_pkg::*;
(
   input  logic                   r_clk,

   input  logic                   wr_en,
   input  logic [byte_addr_w-1:0] wr_addr,
   input  logic [w_data_w-1:0]    wr_byte,

   input  logic                   rd_en,
   input  logic [word_addr_w-1:0] rd_addr,
   output rd_word_u               rd_word
);

   wire [lane_n-1:0]                bank_we;
   wire [word_addr_w-1:0]           bank_waddr;
   wire [lane_sel_w-1:0]            wr_lane;
   wire [lane_n-1:0][w_data_w-1:0]  bank_q;

   // low byte address bits pick the lane, the rest pick the row
   assign wr_lane    = wr_addr[lane_sel_w-1:0];
   assign bank_waddr = wr_addr[byte_addr_w-1 -: word_addr_w];

   for (genvar i = 0; i < lane_n; i++) begin : g_bank
      // write serial, one bank per push
      assign bank_we[i] = wr_en & (wr_lane == lane_sel_w'(i));

      ram_bank #(
         .DATA_W (w_data_w),
         .ADDR_W (word_addr_w)
      ) u_bank (
         .r_clk  (r_clk),
         .w_en   (bank_we[i]),
         .w_addr (bank_waddr),
         .w_data (wr_byte),
         .r_en   (rd_en),
         .r_addr (rd_addr),
         .r_data (bank_q[i])
      );
   end

   // read parallel, all lanes side by side
   assign rd_word.lanes = bank_q;

endmodule

`default_nettype wire

/* src/axil_pkg.sv */
`default_nettype none

// AXI4-Lite side of the capture subsystem
package axil_pkg;

   localparam int axil_addr_w = 12;
   localparam int axil_data_w = 32;

   // response codes
   localparam logic [1:0] resp_okay = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // producer port map
   // byte push, data in wdata[7:0]
   localparam logic [axil_addr_w-1:0] reg_push = 12'h000;
   // write pointer load, value in wdata[9:0]
   localparam logic [axil_addr_w-1:0] reg_wptr = 12'h004;

   // consumer port map
   // buffer window, one word per 4 bytes
   localparam logic [axil_addr_w-1:0] data_base = 12'h000;
   localparam logic [axil_addr_w-1:0] data_span = 12'h400;
   // running byte checksum of returned data words
   localparam logic [axil_addr_w-1:0] reg_chksum = 12'h400;

   localparam int chksum_w = 16;

   // read port sequencer states
   localparam int rd_st_w = 2;
   localparam logic [rd_st_w-1:0] rd_st_idle = 2'd0;
   localparam logic [rd_st_w-1:0] rd_st_wait = 2'd1;
   localparam logic [rd_st_w-1:0] rd_st_resp = 2'd2;

endpackage

`default_nettype wire

/* src/buf_cfg_pkg.sv */
`default_nettype none

// geometry of the capture buffer and the shape of its read word
package buf_cfg_pkg;

   // producer pushes one byte at a time
   localparam int w_data_w = 8;

   // consumer reads whole words
   localparam int r_data_w = 32;

   // one bank per byte lane
   localparam int lane_n = r_data_w / w_data_w;

   // 1 KiB of capture space
   localparam int byte_addr_w = 10;

   localparam int lane_sel_w = $clog2(lane_n);
   localparam int word_addr_w = byte_addr_w - lane_sel_w;

   // read word, seen whole or lane by lane
   // lane 0 sits in the low byte, so the word is little-endian
   typedef union packed {
      logic [r_data_w-1:0] raw;
      logic [lane_n-1:0][w_data_w-1:0] lanes;
   } rd_word_u;

endpackage

`default_nettype wire

/* src/capture_top.sv */
`default_nettype none
`timescale 1ns/100ps

module capture_top
   import axil_pkg::*;
   import buf_cfg_pkg::*;
(
   input  logic                   r_clk,
   input  logic                   arst_n,

   // producer, write only
   input  logic                   wr_awvalid,
   output logic                   wr_awready,
   input  logic [axil_addr_w-1:0] wr_awaddr,
   input  logic                   wr_wvalid,
   output logic                   wr_wready,
   input  logic [axil_data_w-1:0] wr_wdata,
   output logic                   wr_bvalid,
   input  logic                   wr_bready,
   output logic [1:0]             wr_bresp,

   // consumer, read only
   input  logic                   rd_arvalid,
   output logic                   rd_arready,
   input  logic [axil_addr_w-1:0] rd_araddr,
   output logic                   rd_rvalid,
   input  logic                   rd_rready,
   output logic [axil_data_w-1:0] rd_rdata,
   output logic [1:0]             rd_rresp
);

   logic                   buf_wr_en;
   logic [byte_addr_w-1:0] buf_wr_addr;
   logic [w_data_w-1:0]    buf_wr_byte;
   logic                   buf_rd_en;
   logic [word_addr_w-1:0] buf_rd_addr;
   rd_word_u               buf_rd_word;

   sample_writer u_writer (
      .r_clk   (r_clk),
      .arst_n  (arst_n),
      .awvalid (wr_awvalid),
      .awready (wr_awready),
      .awaddr  (wr_awaddr),
      .wvalid  (wr_wvalid),
      .wready  (wr_wready),
      .wdata   (wr_wdata),
      .bvalid  (wr_bvalid),
      .bready  (wr_bready),
      .bresp   (wr_bresp),
      .wr_en   (buf_wr_en),
      .wr_addr (buf_wr_addr),
      .wr_byte (buf_wr_byte)
   );

   asym_ram u_buf (
      .r_clk   (r_clk),
      .wr_en   (buf_wr_en),
      .wr_addr (buf_wr_addr),
      .wr_byte (buf_wr_byte),
      .rd_en   (buf_rd_en),
      .rd_addr (buf_rd_addr),
      .rd_word (buf_rd_word)
   );

   frame_reader u_reader (
      .r_clk   (r_clk),
      .arst_n  (arst_n),
      .arvalid (rd_arvalid),
      .arready (rd_arready),
      .araddr  (rd_araddr),
      .rvalid  (rd_rvalid),
      .rready  (rd_rready),
      .rdata   (rd_rdata),
      .rresp   (rd_rresp),
      .rd_en   (buf_rd_en),
      .rd_addr (buf_rd_addr),
      .rd_word (buf_rd_word)
   );

endmodule

`default_nettype wire

/* src/frame_reader.sv */
`default_nettype none
`timescale 1ns/100ps

module frame_reader
   import axil_pkg::*;
   import buf_cfg_pkg::*;
(
   input  logic                   r_clk,
   input  logic                   arst_n,

   input  logic                   arvalid,
   output logic                   arready,
   input  logic [axil_addr_w-1:0] araddr,
   output logic                   rvalid,
   input  logic                   rready,
   output logic [axil_data_w-1:0] rdata,
   output logic [1:0]             rresp,

   output logic                   rd_en,
   output logic [word_addr_w-1:0] rd_addr,
   input  rd_word_u               rd_word
);

   logic [rd_st_w-1:0]     state;
   logic                   ar_hs;
   logic [axil_addr_w-1:0] data_off;
   logic                   in_data;
   logic                   in_chk;
   logic                   is_data_q;
   logic                   is_chk_q;
   logic [chksum_w-1:0]    chksum;
   logic [chksum_w-1:0]    lane_sum;

   // one read in flight at a time
   assign arready = (state == rd_st_idle);
   assign rvalid  = (state == rd_st_resp);
   assign ar_hs   = arvalid & arready;

   // address decode
   assign data_off = araddr - data_base;
   assign in_data  = (data_off < data_span);
   assign in_chk   = (araddr == reg_chksum);

   // launch the buffer read together with the AR handshake
   assign rd_en   = ar_hs & in_data;
   assign rd_addr = data_off[byte_addr_w-1 -: word_addr_w];

   always_comb begin
      lane_sum = '0;
      for (int i = 0; i < lane_n; i++) begin
         lane_sum = lane_sum + chksum_w'(rd_word.lanes[i]);
      end
   end

   always_ff @(posedge r_clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= rd_st_idle;
         is_data_q <= 1'b0;
         is_chk_q  <= 1'b0;
         chksum    <= '0;
      end else begin
         case (state)
            rd_st_idle: begin
               if (ar_hs) begin
                  state     <= rd_st_wait;
                  is_data_q <= in_data;
                  is_chk_q  <= in_chk;
               end
            end
            // bank output becomes valid in this cycle
            rd_st_wait: state <= rd_st_resp;
            rd_st_resp: begin
               if (rready) begin
                  state <= rd_st_idle;
                  // rd_word still holds the returned word here
                  if (is_data_q) begin
                     chksum <= chksum + lane_sum;
                  end
               end
            end
            default: state <= rd_st_idle;
         endcase
      end
   end

   // response word, loaded on the way into the respond state
   always_ff @(posedge r_clk) begin
      if (state == rd_st_wait) begin
         if (is_data_q) begin
            rdata <= rd_word.raw;
            rresp <= resp_okay;
         end else if (is_chk_q) begin
            rdata <= {{(axil_data_w - chksum_w){1'b0}}, chksum};
            rresp <= resp_okay;
         end else begin
            rdata <= '0;
            rresp <= resp_slverr;
         end
      end
   end

endmodule

`default_nettype wire

/* src/ram_bank.sv */
`default_nettype none
`timescale 1ns/100ps

module ram_bank #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 8
) (
   input  logic              r_clk,
   input  logic              w_en,
   input  logic [ADDR_W-1:0] w_addr,
   input  logic [DATA_W-1:0] w_data,
   input  logic              r_en,
   input  logic [ADDR_W-1:0] r_addr,
   output logic [DATA_W-1:0] r_data
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge r_clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // read register holds between enables
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

/* src/sample_writer.sv */
`default_nettype none
`timescale 1ns/100ps

module sample_writer
   import axil_pkg::*;
   import buf_cfg_pkg::*;
(
   input  logic                   r_clk,
   input  logic                   arst_n,

   input  logic                   awvalid,
   output logic                   awready,
   input  logic [axil_addr_w-1:0] awaddr,
   input  logic                   wvalid,
   output logic                   wready,
   input  logic [axil_data_w-1:0] wdata,
   output logic                   bvalid,
   input  logic                   bready,
   output logic [1:0]             bresp,

   output logic                   wr_en,
   output logic [byte_addr_w-1:0] wr_addr,
   output logic [w_data_w-1:0]    wr_byte
);

   logic                   aw_held;
   logic                   w_held;
   logic [axil_addr_w-1:0] awaddr_q;
   logic [byte_addr_w-1:0] wdata_q;
   logic [byte_addr_w-1:0] wptr;
   logic                   act;
   logic                   hit_push;
   logic                   hit_wptr;

   // each channel stalls once captured, until B completes
   assign awready = ~aw_held;
   assign wready  = ~w_held;

   // both halves in hand and no response outstanding
   assign act      = aw_held & w_held & ~bvalid;
   assign hit_push = (awaddr_q == reg_push);
   assign hit_wptr = (awaddr_q == reg_wptr);

   // exactly one buffer write per push
   assign wr_en   = act & hit_push;
   assign wr_addr = wptr;
   assign wr_byte = wdata_q[w_data_w-1:0];

   // only the low bits of wdata are ever looked at
   always_ff @(posedge r_clk) begin
      if (awvalid && awready) begin
         awaddr_q <= awaddr;
      end
      if (wvalid && wready) begin
         wdata_q <= wdata[byte_addr_w-1:0];
      end
   end

   always_ff @(posedge r_clk or negedge arst_n) begin
      if (!arst_n) begin
         aw_held <= 1'b0;
         w_held  <= 1'b0;
         bvalid  <= 1'b0;
         bresp   <= resp_okay;
         wptr    <= '0;
      end else begin
         if (awvalid && awready) begin
            aw_held <= 1'b1;
         end
         if (wvalid && wready) begin
            w_held <= 1'b1;
         end
         if (act) begin
            bvalid <= 1'b1;
            bresp  <= (hit_push || hit_wptr) ? resp_okay : resp_slverr;
            // pointer wraps at the end of the buffer
            if (hit_push) begin
               wptr <= wptr + 1'b1;
            end else if (hit_wptr) begin
               wptr <= wdata_q;
            end
         end
         if (bvalid && bready) begin
            bvalid  <= 1'b0;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire
